/* Makefile */
# Verilator build and run for the I3C target testbench

VERILATOR ?= verilator
TOP       ?= tb_i3c_target
FLIST     ?= i3c_target.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* i3c_bit_counter.sv */
// SDR frame bit counter
`timescale 1ns/1ps

module i3c_bit_counter (
  input  logic                       clk_SCL_n,
  input  logic                       s0s1_RSTn,
  input  logic                       cnt_clr,
  input  logic                       scl_rise,
  output i3c_target_pkg::bit_idx_t   bit_idx,
  output logic                       frame_done
);

  logic last_bit;

  // bit_idx is the index of the bit taken on the next rise
  assign last_bit = (bit_idx == i3c_target_pkg::NINTH_BIT);

  always_ff @(posedge clk_SCL_n or negedge s0s1_RSTn) begin
    if (!s0s1_RSTn) begin
      bit_idx <= '0;
    end else if (cnt_clr) begin
      bit_idx <= '0;                    // START or idle bus
    end else if (scl_rise) begin
      if (last_bit) begin
        bit_idx <= '0;                  // wrap after the ninth bit
      end else begin
        bit_idx <= bit_idx + 4'd1;
      end
    end
  end

  // same cycle as the ninth sample
  assign frame_done = scl_rise & last_bit & ~cnt_clr;

endmodule

/* i3c_bus_sampler.sv */
// SCL and SDA pin sampler
`timescale 1ns/1ps

module i3c_bus_sampler (
  input  logic clk_SCL_n,
  input  logic s0s1_RSTn,
  input  logic scl_in,
  input  logic sda_in,
  output logic sda_s,
  output logic scl_rise,
  output logic scl_fall,
  output logic start_det,
  output logic stop_det
);

  logic [1:0] scl_sync;                 // [1] is the safe stage
  logic [1:0] sda_sync;
  logic       scl_d;                    // previous sampled level
  logic       sda_d;

  // bus lines idle high, so the synchronizers reset to 1
  always_ff @(posedge clk_SCL_n or negedge s0s1_RSTn) begin
    if (!s0s1_RSTn) begin
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
      scl_d    <= 1'b1;
      sda_d    <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[0], scl_in};
      sda_sync <= {sda_sync[0], sda_in};
      scl_d    <= scl_sync[1];
      sda_d    <= sda_sync[1];
    end
  end

  // event stage, pulses land 3 cycles after the pin change
  always_ff @(posedge clk_SCL_n or negedge s0s1_RSTn) begin
    if (!s0s1_RSTn) begin
      scl_rise  <= 1'b0;
      scl_fall  <= 1'b0;
      start_det <= 1'b0;
      stop_det  <= 1'b0;
    end else begin
      scl_rise  <= scl_sync[1] & ~scl_d;
      scl_fall  <= ~scl_sync[1] & scl_d;
      start_det <= scl_sync[1] & scl_d & sda_d & ~sda_sync[1];  // SDA falls, SCL high
      stop_det  <= scl_sync[1] & scl_d & ~sda_d & sda_sync[1];  // SDA rises, SCL high
    end
  end

  assign sda_s = sda_d;                 // aligned with scl_rise

endmodule

/* i3c_rx_shifter.sv */
// SDR receive shifter with parity check
`timescale 1ns/1ps

module i3c_rx_shifter (
  input  logic                       clk_SCL_n,
  input  logic                       s0s1_RSTn,
  input  logic                       scl_rise,
  input  logic                       sda_s,
  input  i3c_target_pkg::bit_idx_t   bit_idx,
  output i3c_target_pkg::byte_t      rx_byte,
  output logic                       parity_ok
);

  logic data_bit;                       // bits 0 to 7
  logic tbit;                           // bit 8
  logic par_acc;                        // running XOR of the data bits

  assign data_bit = scl_rise & (bit_idx <= i3c_target_pkg::LAST_DATA_BIT);
  assign tbit     = scl_rise & (bit_idx == i3c_target_pkg::NINTH_BIT);

  // MSB arrives first
  always_ff @(posedge clk_SCL_n) begin
    if (data_bit) begin
      rx_byte <= {rx_byte[6:0], sda_s};
    end
  end

  always_ff @(posedge clk_SCL_n or negedge s0s1_RSTn) begin
    if (!s0s1_RSTn) begin
      par_acc   <= 1'b0;
      parity_ok <= 1'b1;
    end else begin
      if (data_bit) begin
        if (bit_idx == '0) begin
          par_acc <= sda_s;             // new frame
        end else begin
          par_acc <= par_acc ^ sda_s;
        end
      end
      if (tbit) begin
        parity_ok <= par_acc ^ sda_s;   // odd over all nine bits
      end
    end
  end

endmodule

/* i3c_target.f */
i3c_target_pkg.sv
i3c_bus_sampler.sv
i3c_bit_counter.sv
i3c_rx_shifter.sv
i3c_tx_shifter.sv
i3c_target_fsm.sv
i3c_target.sv
i3c_target_checker.sv
tb_i3c_target.sv

/* i3c_target.sv */
// I3C SDR target top level
`timescale 1ns/1ps

module i3c_target #(
  parameter i3c_target_pkg::addr7_t STATIC_ADDR = 7'h2A
) (
  input  logic                       clk_SCL_n,
  input  logic                       s0s1_RSTn,
  input  logic                       scl_in,
  input  logic                       sda_in,
  output logic                       sda_out,
  output logic                       sda_oena,
  input  logic                       fb_data_use,
  output i3c_target_pkg::byte_t      fb_datab,
  output logic                       fb_datab_done,
  output logic                       fb_datab_err,
  output logic                       fb_orun,
  input  logic                       tb_data_valid,
  input  i3c_target_pkg::byte_t      tb_datab,
  input  logic                       tb_end,
  output logic                       tb_datab_ack,
  output logic                       tb_urun_nack,
  output logic                       tb_urun,
  output logic                       int_start_seen,
  output logic                       int_sa_matched,
  output logic                       int_7e_matched,
  output logic                       int_in_STOP,
  output logic                       state_dir
);

  logic sda_s, scl_rise, scl_fall, start_det, stop_det;
  logic cnt_clr, frame_done, parity_ok;
  logic tx_load, tx_drive, ack_drive, tx_sda, tx_oena;
  i3c_target_pkg::bit_idx_t bit_idx;
  i3c_target_pkg::byte_t    rx_byte;

  i3c_bus_sampler sampler_i (
    .clk_SCL_n(clk_SCL_n), .s0s1_RSTn(s0s1_RSTn), .scl_in(scl_in), .sda_in(sda_in),
    .sda_s(sda_s), .scl_rise(scl_rise), .scl_fall(scl_fall),
    .start_det(start_det), .stop_det(stop_det));

  i3c_bit_counter counter_i (
    .clk_SCL_n(clk_SCL_n), .s0s1_RSTn(s0s1_RSTn), .cnt_clr(cnt_clr),
    .scl_rise(scl_rise), .bit_idx(bit_idx), .frame_done(frame_done));

  i3c_rx_shifter rx_i (
    .clk_SCL_n(clk_SCL_n), .s0s1_RSTn(s0s1_RSTn), .scl_rise(scl_rise), .sda_s(sda_s),
    .bit_idx(bit_idx), .rx_byte(rx_byte), .parity_ok(parity_ok));

  i3c_tx_shifter tx_i (
    .clk_SCL_n(clk_SCL_n), .s0s1_RSTn(s0s1_RSTn), .tx_load(tx_load),
    .load_byte(tb_datab), .load_more(~tb_end), .scl_fall(scl_fall),
    .tx_drive(tx_drive), .sda_out(tx_sda), .sda_oena(tx_oena));

  i3c_target_fsm #(.STATIC_ADDR(STATIC_ADDR)) fsm_i (
    .clk_SCL_n(clk_SCL_n), .s0s1_RSTn(s0s1_RSTn), .start_det(start_det),
    .stop_det(stop_det), .scl_fall(scl_fall), .frame_done(frame_done),
    .bit_idx(bit_idx), .rx_byte(rx_byte), .parity_ok(parity_ok),
    .fb_data_use(fb_data_use), .tb_data_valid(tb_data_valid), .tb_end(tb_end),
    .cnt_clr(cnt_clr), .tx_load(tx_load), .tx_drive(tx_drive), .ack_drive(ack_drive),
    .int_start_seen(int_start_seen), .int_sa_matched(int_sa_matched),
    .int_7e_matched(int_7e_matched), .int_in_STOP(int_in_STOP), .state_dir(state_dir),
    .fb_datab_done(fb_datab_done), .fb_datab_err(fb_datab_err), .fb_orun(fb_orun),
    .tb_datab_ack(tb_datab_ack), .tb_urun_nack(tb_urun_nack), .tb_urun(tb_urun));

  // ACK pulls SDA low, otherwise the read shifter owns the pin
  assign sda_out  = ack_drive ? 1'b0 : tx_sda;
  assign sda_oena = tx_oena | ack_drive;
  assign fb_datab = rx_byte;            // valid with fb_datab_done

endmodule

/* i3c_target_checker.sv */
// I3C target bus assertions
`timescale 1ns/1ps

module i3c_target_checker (
  input logic clk_SCL_n,
  input logic s0s1_RSTn,
  input logic fb_datab_done,
  input logic fb_orun,
  input logic sda_oena,
  input logic int_in_STOP,
  input logic tb_datab_ack,
  input logic int_start_seen
);

  // a write byte is either taken or dropped
  done_xor_orun: assert property (@(posedge clk_SCL_n) disable iff (!s0s1_RSTn)
    !(fb_datab_done && fb_orun))
    else $error("fb_datab_done and fb_orun in the same cycle");

  // bus in STOP, target keeps off SDA
  idle_no_drive: assert property (@(posedge clk_SCL_n) disable iff (!s0s1_RSTn)
    int_in_STOP |-> !sda_oena)
    else $error("sda_oena high while int_in_STOP");

  ack_one_cycle: assert property (@(posedge clk_SCL_n) disable iff (!s0s1_RSTn)
    tb_datab_ack |=> !tb_datab_ack)
    else $error("tb_datab_ack longer than one cycle");

  // both registered from the same START
  start_leaves_stop: assert property (@(posedge clk_SCL_n) disable iff (!s0s1_RSTn)
    int_start_seen |-> !int_in_STOP)
    else $error("int_in_STOP still high after int_start_seen");

endmodule

bind i3c_target i3c_target_checker checker_i (.*);

/* i3c_target_fsm.sv */
// I3C target protocol FSM
`timescale 1ns/1ps

module i3c_target_fsm #(
  parameter i3c_target_pkg::addr7_t STATIC_ADDR = 7'h2A
) (
  input  logic                       clk_SCL_n,
  input  logic                       s0s1_RSTn,
  input  logic                       start_det,
  input  logic                       stop_det,
  input  logic                       scl_fall,
  input  logic                       frame_done,
  input  i3c_target_pkg::bit_idx_t   bit_idx,
  input  i3c_target_pkg::byte_t      rx_byte,
  input  logic                       parity_ok,
  input  logic                       fb_data_use,
  input  logic                       tb_data_valid,
  input  logic                       tb_end,
  output logic                       cnt_clr,
  output logic                       tx_load,
  output logic                       tx_drive,
  output logic                       ack_drive,
  output logic                       int_start_seen,
  output logic                       int_sa_matched,
  output logic                       int_7e_matched,
  output logic                       int_in_STOP,
  output logic                       state_dir,
  output logic                       fb_datab_done,
  output logic                       fb_datab_err,
  output logic                       fb_orun,
  output logic                       tb_datab_ack,
  output logic                       tb_urun_nack,
  output logic                       tb_urun
);

  i3c_target_pkg::target_state_t state, state_nxt;
  i3c_target_pkg::addr7_t        hdr_addr;
  logic hdr_rnw;
  logic byte_end;                       // SCL fall after data bit 7
  logic hdr_end;
  logic sa_hit;
  logic bc_hit;
  logic hdr_ack;
  logic rd_reload;                      // T-bit of 1 just finished
  logic rd_more;                        // T-bit value of the loaded byte
  logic wr_end;

  // header stays in rx_byte through the ACK bit
  assign hdr_addr  = rx_byte[7:1];
  assign hdr_rnw   = rx_byte[0];
  assign byte_end  = scl_fall & (bit_idx == i3c_target_pkg::NINTH_BIT);
  assign hdr_end   = (state == i3c_target_pkg::ADDR) & byte_end;
  assign sa_hit    = (hdr_addr == STATIC_ADDR);
  assign bc_hit    = (hdr_addr == i3c_target_pkg::BCAST_ADDR) & ~hdr_rnw;  // 7E/R is NACKed
  assign hdr_ack   = bc_hit | (sa_hit & (~hdr_rnw | tb_data_valid));
  assign rd_reload = (state == i3c_target_pkg::RD_TBIT) & scl_fall & rd_more;
  assign wr_end    = (state == i3c_target_pkg::WR_TBIT) & frame_done;

  always_comb begin
    state_nxt = state;
    case (state)
      i3c_target_pkg::ADDR:     if (hdr_end) state_nxt = hdr_ack ? i3c_target_pkg::ADDR_ACK
                                                                  : i3c_target_pkg::WAIT_SR;
      i3c_target_pkg::ADDR_ACK: if (scl_fall) begin
        if (hdr_addr == i3c_target_pkg::BCAST_ADDR) state_nxt = i3c_target_pkg::WAIT_SR;
        else if (hdr_rnw)                            state_nxt = i3c_target_pkg::RD_DATA;
        else                                         state_nxt = i3c_target_pkg::WR_DATA;
      end
      i3c_target_pkg::WR_DATA:  if (byte_end) state_nxt = i3c_target_pkg::WR_TBIT;
      i3c_target_pkg::WR_TBIT:  if (frame_done) state_nxt = i3c_target_pkg::WR_DATA;
      i3c_target_pkg::RD_DATA:  if (byte_end) state_nxt = i3c_target_pkg::RD_TBIT;
      i3c_target_pkg::RD_TBIT:  if (scl_fall) state_nxt = (rd_reload & tb_data_valid)
                                                        ? i3c_target_pkg::RD_DATA
                                                        : i3c_target_pkg::WAIT_SR;
      default: ;                        // IDLE and WAIT_SR sit until START
    endcase
    if (stop_det)       state_nxt = i3c_target_pkg::IDLE;
    else if (start_det) state_nxt = i3c_target_pkg::ADDR;  // also Sr
  end

  always_ff @(posedge clk_SCL_n or negedge s0s1_RSTn) begin
    if (!s0s1_RSTn) begin
      state          <= i3c_target_pkg::IDLE;
      int_start_seen <= 1'b0;
      int_in_STOP    <= 1'b1;
      state_dir      <= 1'b0;
      rd_more        <= 1'b0;
      fb_datab_done  <= 1'b0;
      fb_orun        <= 1'b0;
    end else begin
      state          <= state_nxt;
      int_start_seen <= start_det;
      fb_datab_done  <= wr_end & fb_data_use;
      fb_orun        <= wr_end & ~fb_data_use;  // byte dropped
      if (stop_det)        int_in_STOP <= 1'b1;
      else if (start_det)  int_in_STOP <= 1'b0;
      if (start_det | stop_det)  state_dir <= 1'b0;
      else if (hdr_end & hdr_ack) state_dir <= hdr_rnw;
      if (tx_load) rd_more <= ~tb_end;
    end
  end

  // parity_ok is registered on the ninth rise, valid with done
  assign fb_datab_err   = fb_datab_done & ~parity_ok;

  assign cnt_clr        = start_det | (state == i3c_target_pkg::IDLE);
  assign tx_load        = (hdr_end & sa_hit & hdr_rnw & tb_data_valid) |
                          (rd_reload & tb_data_valid);
  assign tb_datab_ack   = tx_load;
  assign tb_urun_nack   = hdr_end & sa_hit & hdr_rnw & ~tb_data_valid;
  assign tb_urun        = rd_reload & ~tb_data_valid;
  assign int_sa_matched = hdr_end & sa_hit;
  assign int_7e_matched = hdr_end & bc_hit;
  assign tx_drive       = (state == i3c_target_pkg::RD_DATA) |
                          (state == i3c_target_pkg::RD_TBIT);
  assign ack_drive      = (state == i3c_target_pkg::ADDR_ACK);

endmodule

/* i3c_target_input.txt */
# kind addr ack nbytes b0 b1 b2 b3 mask   (addr, bytes and mask in hex)
# kinds W write, O write with fb_data_use low, R read, U read with tb_data_valid low
# mask bit k: W sends a bad T-bit on byte k, R raises tb_end on byte k
W 2A 1 3 A5 00 FF 3C 0
W 2A 1 2 81 7E 00 00 2
W 2A 1 1 F0 00 00 00 1
W 2A 1 4 01 02 04 08 5
O 2A 1 2 12 34 00 00 0
W 2A 1 1 5A 00 00 00 0
R 2A 1 3 C3 5A 01 00 4
R 2A 1 1 96 00 00 00 1
R 2A 1 4 80 01 FE 7F 8
U 2A 0 2 11 22 00 00 2
R 2A 1 2 E7 18 00 00 2
W 15 0 0 00 00 00 00 0
R 15 0 0 00 00 00 00 0
W 7E 1 0 00 00 00 00 0
R 7E 0 0 00 00 00 00 0
W 2A 1 2 FF 00 00 00 3

/* i3c_target_pkg.sv */
// I3C target shared types
package i3c_target_pkg;

  // one SDR data byte as seen on the bus
  typedef logic [7:0] byte_t;

  // 7-bit bus address, header bits 7:1
  typedef logic [6:0] addr7_t;

  // bit position inside a 9-bit frame, 0 to 8
  typedef logic [3:0] bit_idx_t;

  // protocol states of the target
  typedef enum logic [2:0] {
    IDLE,       // bus in STOP, nothing to do
    ADDR,       // shifting in the address header
    ADDR_ACK,   // driving the ACK bit
    WR_DATA,    // private write, data bits
    WR_TBIT,    // private write, parity T-bit
    RD_DATA,    // private read, data bits
    RD_TBIT,    // private read, end-of-data T-bit
    WAIT_SR     // not addressed, wait for Sr or STOP
  } target_state_t;

  // broadcast address, matched for writes only
  localparam addr7_t BCAST_ADDR = 7'h7E;

  // index of the last data bit in a frame
  localparam bit_idx_t LAST_DATA_BIT = 4'd7;

  // index of the ninth bit (ACK or T-bit)
  localparam bit_idx_t NINTH_BIT = 4'd8;

endpackage

/* i3c_tx_shifter.sv */
// SDR transmit shifter
`timescale 1ns/1ps

module i3c_tx_shifter (
  input  logic                       clk_SCL_n,
  input  logic                       s0s1_RSTn,
  input  logic                       tx_load,
  input  i3c_target_pkg::byte_t      load_byte,
  input  logic                       load_more,
  input  logic                       scl_fall,
  input  logic                       tx_drive,
  output logic                       sda_out,
  output logic                       sda_oena
);

  logic [8:0] tx_sr;                    // data bits then the T-bit

  // load wins over a shift on the same fall
  always_ff @(posedge clk_SCL_n or negedge s0s1_RSTn) begin
    if (!s0s1_RSTn) begin
      tx_sr <= '1;
    end else if (tx_load) begin
      tx_sr <= {load_byte, load_more};
    end else if (scl_fall & tx_drive) begin
      tx_sr <= {tx_sr[7:0], 1'b1};      // next bit on each SCL fall
    end
  end

  assign sda_out  = tx_sr[8];
  assign sda_oena = tx_drive;           // only during read data and T-bit

endmodule

/* tb_i3c_target.sv */
// I3C target testbench
`timescale 1ns/1ps

module tb_i3c_target;

  localparam i3c_target_pkg::addr7_t SA = 7'h2A;
  localparam int WAIT_LIMIT = 400;

  logic clk_SCL_n = 1'b0;
  logic s0s1_RSTn;
  logic scl_c;                          // controller SCL
  logic sda_c;                          // controller SDA drive, 1 releases
  logic sda_line;
  logic fb_data_use;
  logic tb_data_valid;
  i3c_target_pkg::byte_t tb_datab = '0;
  logic tb_end = 1'b1;
  i3c_target_pkg::byte_t fb_datab;
  logic sda_out, sda_oena, fb_datab_done, fb_datab_err, fb_orun;
  logic tb_datab_ack, tb_urun_nack, tb_urun;
  logic int_start_seen, int_sa_matched, int_7e_matched, int_in_STOP, state_dir;

  i3c_target_pkg::byte_t rd_bytes [8];
  logic rd_end [8];
  i3c_target_pkg::byte_t tbytes [4];    // bytes of the current line
  i3c_target_pkg::byte_t wr_q [$];
  logic err_q [$];
  int orun_cnt = 0;
  int ack_cnt = 0;
  int sa_cnt = 0;
  int bc_cnt = 0;
  int unack_cnt = 0;
  int start_cnt = 0;
  int urun_cnt = 0;
  int ack_base = 0;
  int errors = 0;
  int checks = 0;
  bit timed_out = 1'b0;

  assign sda_line = sda_c & ~(sda_oena & ~sda_out);  // open drain

  always #50 clk_SCL_n = ~clk_SCL_n;

  i3c_target #(.STATIC_ADDR(SA)) dut_i (
    .clk_SCL_n(clk_SCL_n), .s0s1_RSTn(s0s1_RSTn), .scl_in(scl_c), .sda_in(sda_line),
    .sda_out(sda_out), .sda_oena(sda_oena), .fb_data_use(fb_data_use),
    .fb_datab(fb_datab), .fb_datab_done(fb_datab_done), .fb_datab_err(fb_datab_err),
    .fb_orun(fb_orun), .tb_data_valid(tb_data_valid), .tb_datab(tb_datab),
    .tb_end(tb_end), .tb_datab_ack(tb_datab_ack), .tb_urun_nack(tb_urun_nack),
    .tb_urun(tb_urun), .int_start_seen(int_start_seen), .int_sa_matched(int_sa_matched),
    .int_7e_matched(int_7e_matched), .int_in_STOP(int_in_STOP), .state_dir(state_dir));

  // strobe counters, and the read byte port that follows each ack
  always @(posedge clk_SCL_n) begin : bus_monitor
    int sel;
    sel = ack_cnt + int'(tb_datab_ack) - ack_base;
    tb_datab <= rd_bytes[sel[2:0]];
    tb_end   <= rd_end[sel[2:0]];
    if (tb_datab_ack)   ack_cnt   <= ack_cnt + 1;
    if (fb_orun)        orun_cnt  <= orun_cnt + 1;
    if (int_sa_matched) sa_cnt    <= sa_cnt + 1;
    if (int_7e_matched) bc_cnt    <= bc_cnt + 1;
    if (tb_urun_nack)   unack_cnt <= unack_cnt + 1;
    if (int_start_seen) start_cnt <= start_cnt + 1;
    if (tb_urun)        urun_cnt  <= urun_cnt + 1;
    if (fb_datab_done) begin
      wr_q.push_back(fb_datab);
      err_q.push_back(fb_datab_err);
    end
  end

  task automatic check_byte(input string name, input i3c_target_pkg::byte_t got,
                            input i3c_target_pkg::byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic tick(input int n);
    repeat (n) @(posedge clk_SCL_n);
  endtask

  // one SCL period, 4 clocks low and 4 high, SDA set mid-low
  task automatic drive_bit(input logic b, output logic seen);
    scl_c <= 1'b0;
    tick(2);
    sda_c <= b;
    tick(2);
    scl_c <= 1'b1;
    tick(4);
    seen = sda_line;
  endtask

  task automatic bus_start();
    sda_c <= 1'b0;                      // SDA falls with SCL high
    tick(4);
  endtask

  task automatic bus_stop();
    scl_c <= 1'b0;
    tick(2);
    sda_c <= 1'b0;
    tick(2);
    scl_c <= 1'b1;
    tick(4);
    sda_c <= 1'b1;
    tick(8);
  endtask

  task automatic send_header(input logic [6:0] addr, input logic rnw, output logic acked);
    logic s;
    for (int i = 6; i >= 0; i--) drive_bit(addr[i], s);
    drive_bit(rnw, s);
    drive_bit(1'b1, s);
    acked = ~s;                         // target pulls low to ACK
  endtask

  task automatic write_byte(input i3c_target_pkg::byte_t b, input logic bad);
    logic s;
    for (int i = 7; i >= 0; i--) drive_bit(b[i], s);
    drive_bit(~^b ^ bad, s);            // odd parity over nine bits
  endtask

  task automatic read_byte(output i3c_target_pkg::byte_t v, output logic t);
    logic s;
    for (int i = 7; i >= 0; i--) begin
      drive_bit(1'b1, s);
      v[i] = s;
    end
    drive_bit(1'b1, t);
  endtask

  task automatic wait_writes(input int need, input int or0);
    int n;
    n = 0;
    while (wr_q.size() + orun_cnt - or0 < need && n < WAIT_LIMIT) begin
      @(posedge clk_SCL_n);
      n++;
    end
    if (wr_q.size() + orun_cnt - or0 < need) begin
      timed_out = 1'b1;
      errors++;
      $display("timeout at %0t: write bytes never reached the from-bus port", $time);
    end
  endtask

  task automatic wait_acks(input int need);
    int n;
    n = 0;
    while (ack_cnt < need && n < WAIT_LIMIT) begin
      @(posedge clk_SCL_n);
      n++;
    end
    if (ack_cnt < need) begin
      timed_out = 1'b1;
      errors++;
      $display("timeout at %0t: tb_datab_ack count stayed short", $time);
    end
  endtask

  task automatic run_test(input string kind, input logic [6:0] addr, input logic exp_ack,
                          input int nb, input logic [3:0] mask);
    int sa0, bc0, un0, or0, a0, st0, ur0, n_rd, n_wr, nq;
    logic rnw, acked, tbit;
    i3c_target_pkg::byte_t got;
    sa0 = sa_cnt;
    bc0 = bc_cnt;
    un0 = unack_cnt;
    or0 = orun_cnt;
    a0  = ack_cnt;
    st0 = start_cnt;
    ur0 = urun_cnt;
    rnw = (kind == "R") || (kind == "U");
    n_rd = 0;
    for (int k = 0; k < nb; k++) begin
      n_rd++;
      if (mask[k]) break;               // last byte has tb_end high
    end
    if (!rnw || !exp_ack) n_rd = 0;
    n_wr = (!rnw && exp_ack && addr == SA) ? nb : 0;
    fb_data_use   <= (kind != "O");
    tb_data_valid <= (kind != "U");
    ack_base      <= ack_cnt;
    for (int k = 0; k < 4; k++) begin
      rd_bytes[k] <= tbytes[k];
      rd_end[k]   <= mask[k];
    end
    tick(4);
    bus_start();
    send_header(addr, rnw, acked);
    check_bit("ack", acked, exp_ack);
    check_bit("state_dir", state_dir, rnw & exp_ack);
    if (acked && addr != i3c_target_pkg::BCAST_ADDR) begin
      for (int k = 0; k < nb; k++) begin
        if (rnw) begin
          read_byte(got, tbit);
          check_byte("rd_byte", got, tbytes[k]);
          check_bit("rd_tbit", tbit, ~mask[k]);
          if (!tbit) break;
        end else begin
          write_byte(tbytes[k], mask[k]);
        end
      end
    end
    bus_stop();
    wait_writes(n_wr, or0);
    if (!timed_out) begin
      wait_acks(a0 + n_rd);
    end
    if (timed_out) begin
      return;
    end
    nq = wr_q.size();
    if (kind == "O") begin
      check_count("fb_orun", orun_cnt - or0, n_wr);
      check_count("fb_datab_done", nq, 0);
    end else begin
      check_count("fb_datab_done", nq, n_wr);
      for (int k = 0; k < nq && k < 4; k++) begin
        check_byte("fb_datab", wr_q[k], tbytes[k]);
        check_bit("fb_datab_err", err_q[k], mask[k]);
      end
    end
    wr_q.delete();
    err_q.delete();
    check_count("int_start_seen", start_cnt - st0, 1);
    check_count("int_sa_matched", sa_cnt - sa0, int'(addr == SA));
    check_count("int_7e_matched", bc_cnt - bc0,
                int'(addr == i3c_target_pkg::BCAST_ADDR && exp_ack));
    check_count("tb_datab_ack", ack_cnt - a0, n_rd);
    check_count("tb_urun_nack", unack_cnt - un0, int'(kind == "U"));
    check_count("tb_urun", urun_cnt - ur0, 0);
  endtask

  initial begin : main
    int fd, r, n_test, e0;
    int addr, exp_ack, nb, b0, b1, b2, b3, mask;
    string line, kind;
    s0s1_RSTn     <= 1'b0;
    scl_c         <= 1'b1;
    sda_c         <= 1'b1;
    fb_data_use   <= 1'b1;
    tb_data_valid <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      rd_bytes[i] <= '0;
      rd_end[i]   <= 1'b1;
    end
    tick(5);
    s0s1_RSTn <= 1'b1;
    tick(8);
    check_bit("int_in_STOP", int_in_STOP, 1'b1);
    check_bit("sda_oena", sda_oena, 1'b0);
    check_bit("state_dir", state_dir, 1'b0);
    check_count("strobes", sa_cnt + bc_cnt + orun_cnt + ack_cnt + unack_cnt +
                start_cnt + urun_cnt + wr_q.size(), 0);
    $display("test 0: reset state %s", (errors == 0) ? "ok" : "has errors");
    n_test = 1;
    fd = $fopen("i3c_target_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open i3c_target_input.txt");
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        r = $fgets(line, fd);
        if (r > 0 && line.len() > 1 && line.getc(0) != "#") begin
          r = $sscanf(line, "%s %h %d %d %h %h %h %h %h",
                      kind, addr, exp_ack, nb, b0, b1, b2, b3, mask);
          if (r == 9) begin
            e0 = errors;
            tbytes[0] = b0[7:0];
            tbytes[1] = b1[7:0];
            tbytes[2] = b2[7:0];
            tbytes[3] = b3[7:0];
            run_test(kind, addr[6:0], exp_ack[0], nb, mask[3:0]);
            $display("test %0d: %s addr %h %s", n_test, kind, addr[6:0],
                     (errors == e0) ? "ok" : "has errors");
            n_test++;
          end
        end
      end
      $fclose(fd);
      $display("%0d tests, %0d checks, %0d errors", n_test, checks, errors);
      if (errors == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule
